//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // All zero means a read.

  // Memory map, top addresses are exclusive.
  localparam addr_t rom_base_addr  = 32'h0000_0000;
  localparam addr_t rom_top_addr   = 32'h0000_1000;

  localparam addr_t tim0_base_addr = 32'h1000_0000;
  localparam addr_t tim0_top_addr  = 32'h1000_1000;

  localparam addr_t tim1_base_addr = 32'h2000_0000;
  localparam addr_t tim1_top_addr  = 32'h2000_1000;

  localparam data_t rom_pattern    = 32'h9e37_79b9;

  // ROM word k holds k times the pattern, low 32 bits kept.
  function automatic data_t rom_word(input addr_t index);
    return data_t'(index * rom_pattern);
  endfunction

endpackage

`default_nettype wire

//--- bus_decoder.sv
`default_nettype none

module bus_decoder (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           mem_valid,
  input  soc_pkg::addr_t mem_addr,
  input  soc_pkg::data_t mem_wdata,
  input  soc_pkg::strb_t mem_wstrb,
  output soc_pkg::data_t mem_rdata,
  output logic           mem_ready,
  output logic           rom_valid,
  output logic           tim0_valid,
  output logic           tim1_valid,
  output soc_pkg::addr_t tgt_addr,
  output soc_pkg::data_t tgt_wdata,
  output soc_pkg::strb_t tgt_wstrb,
  input  soc_pkg::data_t rom_rdata,
  input  logic           rom_ready,
  input  soc_pkg::data_t tim0_rdata,
  input  logic           tim0_ready,
  input  soc_pkg::data_t tim1_rdata,
  input  logic           tim1_ready
);

  import soc_pkg::*;

  addr_t base;
  logic  unmapped;
  logic  unmapped_q;

  always_comb begin
    rom_valid  = 1'b0;
    tim0_valid = 1'b0;
    tim1_valid = 1'b0;
    unmapped   = 1'b0;
    base       = '0;
    if (mem_addr >= tim1_base_addr && mem_addr < tim1_top_addr) begin
      tim1_valid = mem_valid;
      base       = tim1_base_addr;
    end else if (mem_addr >= tim0_base_addr && mem_addr < tim0_top_addr) begin
      tim0_valid = mem_valid;
      base       = tim0_base_addr;
    end else if (mem_addr >= rom_base_addr && mem_addr < rom_top_addr) begin
      rom_valid  = mem_valid;
      base       = rom_base_addr;
    end else begin
      unmapped   = mem_valid;  // No region claims it.
    end
  end

  assign tgt_addr  = mem_addr - base;
  assign tgt_wdata = mem_wdata;
  assign tgt_wstrb = mem_wstrb;

  // Gated by its own output so a held valid answers only once.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= unmapped && !unmapped_q;
    end
  end

  always_comb begin
    if (tim1_ready) begin
      mem_rdata = tim1_rdata;
    end else if (tim0_ready) begin
      mem_rdata = tim0_rdata;
    end else if (rom_ready) begin
      mem_rdata = rom_rdata;
    end else begin
      mem_rdata = '0;  // Unmapped or idle.
    end
  end

  assign mem_ready = tim1_ready | tim0_ready | rom_ready | unmapped_q;

endmodule

`default_nettype wire

//--- port_arbiter.sv
`default_nettype none

module port_arbiter (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           i_valid,
  input  soc_pkg::addr_t i_addr,
  input  soc_pkg::data_t i_wdata,
  input  soc_pkg::strb_t i_wstrb,
  output soc_pkg::data_t i_rdata,
  output logic           i_ready,
  input  logic           d_valid,
  input  soc_pkg::addr_t d_addr,
  input  soc_pkg::data_t d_wdata,
  input  soc_pkg::strb_t d_wstrb,
  output soc_pkg::data_t d_rdata,
  output logic           d_ready,
  output logic           tgt_valid,
  output soc_pkg::addr_t tgt_addr,
  output soc_pkg::data_t tgt_wdata,
  output soc_pkg::strb_t tgt_wstrb,
  input  soc_pkg::data_t tgt_rdata,
  input  logic           tgt_ready
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_issue,
    st_wait
  } state_t;

  state_t state;
  logic   grant_d;  // Data side owns the target.
  logic   resp_q;
  data_t  rdata_q;

  // Wait covers the answer cycle too, so a held valid is not granted twice.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      grant_d <= 1'b0;
      resp_q  <= 1'b0;
    end else begin
      resp_q <= 1'b0;
      case (state)
        st_idle: begin
          if (d_valid || i_valid) begin
            grant_d <= d_valid;  // Data first.
            state   <= st_issue;
          end
        end
        st_issue: begin
          state <= st_wait;
        end
        st_wait: begin
          if (resp_q) begin
            state <= st_idle;
          end else if (tgt_ready) begin
            resp_q <= 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_wait && tgt_ready) begin
      rdata_q <= tgt_rdata;
    end
  end

  assign tgt_valid = (state == st_issue);
  assign tgt_addr  = grant_d ? d_addr : i_addr;
  assign tgt_wdata = grant_d ? d_wdata : i_wdata;
  assign tgt_wstrb = grant_d ? d_wstrb : i_wstrb;

  assign i_ready = resp_q && !grant_d;
  assign d_ready = resp_q && grant_d;
  assign i_rdata = i_ready ? rdata_q : '0;
  assign d_rdata = d_ready ? rdata_q : '0;

endmodule

`default_nettype wire

//--- tim.sv
`default_nettype none

module tim #(
  parameter int unsigned tim_words = 256
) (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           mem_valid,
  input  soc_pkg::addr_t mem_addr,
  input  soc_pkg::data_t mem_wdata,
  input  soc_pkg::strb_t mem_wstrb,
  output soc_pkg::data_t mem_rdata,
  output logic           mem_ready
);

  import soc_pkg::*;

  localparam int unsigned idx_w = $clog2(tim_words);

  data_t            mem [tim_words];
  logic [idx_w-1:0] word_idx;

  assign word_idx = idx_w'((mem_addr >> 2) % tim_words);  // Offsets wrap.

  always_ff @(posedge clock) begin
    if (mem_valid) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) begin
          mem[word_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
      mem_rdata <= (mem_wstrb == '0) ? mem[word_idx] : '0;  // Writes return zero.
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= mem_valid;
    end
  end

endmodule

`default_nettype wire

//--- boot_rom.sv
`default_nettype none

module boot_rom (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           mem_valid,
  input  soc_pkg::addr_t mem_addr,
  input  soc_pkg::data_t mem_wdata,
  input  soc_pkg::strb_t mem_wstrb,
  output soc_pkg::data_t mem_rdata,
  output logic           mem_ready
);

  import soc_pkg::*;

  // Contents are computed, writes only get an empty answer.
  always_ff @(posedge clock) begin
    if (mem_valid) begin
      mem_rdata <= (mem_wstrb == '0) ? rom_word(mem_addr >> 2) : '0;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= mem_valid;
    end
  end

endmodule

`default_nettype wire

//--- soc_fabric.sv
`default_nettype none

module soc_fabric #(
  parameter int unsigned tim_words = 256
) (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           imem_valid,
  input  soc_pkg::addr_t imem_addr,
  input  soc_pkg::data_t imem_wdata,
  input  soc_pkg::strb_t imem_wstrb,
  output soc_pkg::data_t imem_rdata,
  output logic           imem_ready,
  input  logic           dmem_valid,
  input  soc_pkg::addr_t dmem_addr,
  input  soc_pkg::data_t dmem_wdata,
  input  soc_pkg::strb_t dmem_wstrb,
  output soc_pkg::data_t dmem_rdata,
  output logic           dmem_ready
);

  import soc_pkg::*;

  // Instruction decoder side.
  logic  irom_valid, itim0_valid, itim1_valid;
  logic  irom_ready, itim0_ready, itim1_ready;
  data_t irom_rdata, itim0_rdata, itim1_rdata;
  addr_t iaddr;
  data_t iwdata;
  strb_t iwstrb;

  // Data decoder side.
  logic  drom_valid, dtim0_valid, dtim1_valid;
  logic  drom_ready, dtim0_ready, dtim1_ready;
  data_t drom_rdata, dtim0_rdata, dtim1_rdata;
  addr_t daddr;
  data_t dwdata;
  strb_t dwstrb;

  // Target side.
  logic  rom_valid, tim0_valid, tim1_valid;
  logic  rom_ready, tim0_ready, tim1_ready;
  addr_t rom_addr, tim0_addr, tim1_addr;
  data_t rom_wdata, tim0_wdata, tim1_wdata;
  strb_t rom_wstrb, tim0_wstrb, tim1_wstrb;
  data_t rom_rdata, tim0_rdata, tim1_rdata;

  bus_decoder decoder_imem_comp (
    .clock (clock), .arst_n (arst_n),
    .mem_valid (imem_valid), .mem_addr (imem_addr),
    .mem_wdata (imem_wdata), .mem_wstrb (imem_wstrb),
    .mem_rdata (imem_rdata), .mem_ready (imem_ready),
    .rom_valid (irom_valid), .tim0_valid (itim0_valid), .tim1_valid (itim1_valid),
    .tgt_addr (iaddr), .tgt_wdata (iwdata), .tgt_wstrb (iwstrb),
    .rom_rdata (irom_rdata), .rom_ready (irom_ready),
    .tim0_rdata (itim0_rdata), .tim0_ready (itim0_ready),
    .tim1_rdata (itim1_rdata), .tim1_ready (itim1_ready)
  );

  bus_decoder decoder_dmem_comp (
    .clock (clock), .arst_n (arst_n),
    .mem_valid (dmem_valid), .mem_addr (dmem_addr),
    .mem_wdata (dmem_wdata), .mem_wstrb (dmem_wstrb),
    .mem_rdata (dmem_rdata), .mem_ready (dmem_ready),
    .rom_valid (drom_valid), .tim0_valid (dtim0_valid), .tim1_valid (dtim1_valid),
    .tgt_addr (daddr), .tgt_wdata (dwdata), .tgt_wstrb (dwstrb),
    .rom_rdata (drom_rdata), .rom_ready (drom_ready),
    .tim0_rdata (dtim0_rdata), .tim0_ready (dtim0_ready),
    .tim1_rdata (dtim1_rdata), .tim1_ready (dtim1_ready)
  );

  port_arbiter arbiter_rom_comp (
    .clock (clock), .arst_n (arst_n),
    .i_valid (irom_valid), .i_addr (iaddr), .i_wdata (iwdata), .i_wstrb (iwstrb),
    .i_rdata (irom_rdata), .i_ready (irom_ready),
    .d_valid (drom_valid), .d_addr (daddr), .d_wdata (dwdata), .d_wstrb (dwstrb),
    .d_rdata (drom_rdata), .d_ready (drom_ready),
    .tgt_valid (rom_valid), .tgt_addr (rom_addr),
    .tgt_wdata (rom_wdata), .tgt_wstrb (rom_wstrb),
    .tgt_rdata (rom_rdata), .tgt_ready (rom_ready)
  );

  port_arbiter arbiter_tim0_comp (
    .clock (clock), .arst_n (arst_n),
    .i_valid (itim0_valid), .i_addr (iaddr), .i_wdata (iwdata), .i_wstrb (iwstrb),
    .i_rdata (itim0_rdata), .i_ready (itim0_ready),
    .d_valid (dtim0_valid), .d_addr (daddr), .d_wdata (dwdata), .d_wstrb (dwstrb),
    .d_rdata (dtim0_rdata), .d_ready (dtim0_ready),
    .tgt_valid (tim0_valid), .tgt_addr (tim0_addr),
    .tgt_wdata (tim0_wdata), .tgt_wstrb (tim0_wstrb),
    .tgt_rdata (tim0_rdata), .tgt_ready (tim0_ready)
  );

  port_arbiter arbiter_tim1_comp (
    .clock (clock), .arst_n (arst_n),
    .i_valid (itim1_valid), .i_addr (iaddr), .i_wdata (iwdata), .i_wstrb (iwstrb),
    .i_rdata (itim1_rdata), .i_ready (itim1_ready),
    .d_valid (dtim1_valid), .d_addr (daddr), .d_wdata (dwdata), .d_wstrb (dwstrb),
    .d_rdata (dtim1_rdata), .d_ready (dtim1_ready),
    .tgt_valid (tim1_valid), .tgt_addr (tim1_addr),
    .tgt_wdata (tim1_wdata), .tgt_wstrb (tim1_wstrb),
    .tgt_rdata (tim1_rdata), .tgt_ready (tim1_ready)
  );

  boot_rom rom_comp (
    .clock (clock), .arst_n (arst_n),
    .mem_valid (rom_valid), .mem_addr (rom_addr),
    .mem_wdata (rom_wdata), .mem_wstrb (rom_wstrb),
    .mem_rdata (rom_rdata), .mem_ready (rom_ready)
  );

  tim #(
    .tim_words (tim_words)
  ) tim0_comp (
    .clock (clock), .arst_n (arst_n),
    .mem_valid (tim0_valid), .mem_addr (tim0_addr),
    .mem_wdata (tim0_wdata), .mem_wstrb (tim0_wstrb),
    .mem_rdata (tim0_rdata), .mem_ready (tim0_ready)
  );

  tim #(
    .tim_words (tim_words)
  ) tim1_comp (
    .clock (clock), .arst_n (arst_n),
    .mem_valid (tim1_valid), .mem_addr (tim1_addr),
    .mem_wdata (tim1_wdata), .mem_wstrb (tim1_wstrb),
    .mem_rdata (tim1_rdata), .mem_ready (tim1_ready)
  );

endmodule

`default_nettype wire

//--- soc_fabric_checker.sv
`default_nettype none

module soc_fabric_checker (
  input logic clock,
  input logic arst_n,
  input logic arb_idle,
  input logic tgt_valid,
  input logic i_ready,
  input logic d_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fails = 0;

  tgt_valid_single: assert property (@(posedge clock) disable iff (!arst_n)
    tgt_valid |=> !tgt_valid)
    else begin
      $error("tgt_valid lasted longer than one cycle");
      fails++;
    end

  ready_one_side: assert property (@(posedge clock) disable iff (!arst_n)
    !(i_ready && d_ready))
    else begin
      $error("i_ready and d_ready are high together");
      fails++;
    end

  // An idle arbiter has no answer pending.
  no_ready_idle: assert property (@(posedge clock) disable iff (!arst_n)
    arb_idle |-> !(i_ready || d_ready))
    else begin
      $error("ready seen while the arbiter is idle");
      fails++;
    end

endmodule

bind port_arbiter soc_fabric_checker arbiter_checks (
  .clock     (clock),
  .arst_n    (arst_n),
  .arb_idle  (state == st_idle),
  .tgt_valid (tgt_valid),
  .i_ready   (i_ready),
  .d_ready   (d_ready)
);

`default_nettype wire

//--- tb_soc_fabric.sv
`default_nettype none

module tb_soc_fabric;

  timeunit 1ns;
  timeprecision 1ps;

  import soc_pkg::*;

  localparam int unsigned tim_words       = 256;
  localparam int unsigned random_per_port = 200;
  localparam int unsigned total_accesses  = 2 * tim_words + 54 + 2 * random_per_port;
  localparam int unsigned timeout_cycles  = 20 * total_accesses;

  logic  clock, arst_n;
  logic  imem_valid, imem_ready, dmem_valid, dmem_ready;
  addr_t imem_addr, dmem_addr;
  data_t imem_wdata, imem_rdata, dmem_wdata, dmem_rdata;
  strb_t imem_wstrb, dmem_wstrb;

  data_t tim0_model [tim_words];
  data_t tim1_model [tim_words];
  string name_q [$];
  data_t exp_q [$];
  data_t act_q [$];
  string cur_test;
  int    checks, errors, test_checks, test_errors, tests, checker_fails;
  int    cycle_count = 0;
  int    imem_done, dmem_done;

  soc_fabric #(.tim_words (tim_words)) UUT (
    .clock (clock), .arst_n (arst_n),
    .imem_valid (imem_valid), .imem_addr (imem_addr), .imem_wdata (imem_wdata),
    .imem_wstrb (imem_wstrb), .imem_rdata (imem_rdata), .imem_ready (imem_ready),
    .dmem_valid (dmem_valid), .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb), .dmem_rdata (dmem_rdata), .dmem_ready (dmem_ready)
  );

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic int unsigned tim_index(input addr_t offset);
    return (offset >> 2) % tim_words;  // Offsets wrap.
  endfunction

  function automatic data_t fill_word(input addr_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5ac3_3ca5;
  endfunction

  function automatic data_t ref_read(input addr_t addr, input strb_t wstrb);
    if (wstrb != '0) begin
      return '0;
    end else if (addr >= tim1_base_addr && addr < tim1_top_addr) begin
      return tim1_model[tim_index(addr - tim1_base_addr)];
    end else if (addr >= tim0_base_addr && addr < tim0_top_addr) begin
      return tim0_model[tim_index(addr - tim0_base_addr)];
    end else if (addr >= rom_base_addr && addr < rom_top_addr) begin
      return data_t'(((addr - rom_base_addr) >> 2) * rom_pattern);
    end
    return '0;  // Unmapped.
  endfunction

  function automatic void write_model(input addr_t addr, input data_t wdata, input strb_t wstrb);
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b] && addr >= tim0_base_addr && addr < tim0_top_addr) begin
        tim0_model[tim_index(addr - tim0_base_addr)][8*b +: 8] = wdata[8*b +: 8];
      end else if (wstrb[b] && addr >= tim1_base_addr && addr < tim1_top_addr) begin
        tim1_model[tim_index(addr - tim1_base_addr)][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endfunction

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_order(input int d_cycle, input int i_cycle);
    checks++;
    if (d_cycle > i_cycle) begin
      errors++;
      $display("%s: dmem ready came after imem ready under contention", cur_test);
    end
  endtask

  always @(posedge clock) begin
    while (act_q.size() > 0) begin
      check_data(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  task automatic record_result(input addr_t addr, input data_t wdata, input strb_t wstrb,
                               input data_t rdata);
    name_q.push_back($sformatf("%s @%h", cur_test, addr));
    exp_q.push_back(ref_read(addr, wstrb));
    act_q.push_back(rdata);
    write_model(addr, wdata, wstrb);
  endtask

  task automatic imem_access(input addr_t addr, input data_t wdata, input strb_t wstrb);
    @(posedge clock);
    imem_valid <= 1'b1;
    imem_addr  <= addr;
    imem_wdata <= wdata;
    imem_wstrb <= wstrb;
    @(negedge clock);
    while (!imem_ready) @(negedge clock);
    imem_done = cycle_count;
    record_result(addr, wdata, wstrb, imem_rdata);
    @(posedge clock);
    imem_valid <= 1'b0;
  endtask

  task automatic dmem_access(input addr_t addr, input data_t wdata, input strb_t wstrb);
    @(posedge clock);
    dmem_valid <= 1'b1;
    dmem_addr  <= addr;
    dmem_wdata <= wdata;
    dmem_wstrb <= wstrb;
    @(negedge clock);
    while (!dmem_ready) @(negedge clock);
    dmem_done = cycle_count;
    record_result(addr, wdata, wstrb, dmem_rdata);
    @(posedge clock);
    dmem_valid <= 1'b0;
  endtask

  task automatic port_access(input bit on_dmem, input addr_t addr, input data_t wdata,
                             input strb_t wstrb);
    if (on_dmem) begin
      dmem_access(addr, wdata, wstrb);
    end else begin
      imem_access(addr, wdata, wstrb);
    end
  endtask

  task automatic fill_tim(input bit on_dmem);
    addr_t addr;
    for (int w = 0; w < tim_words; w++) begin
      addr = (on_dmem ? tim1_base_addr : tim0_base_addr) + 4 * w;
      port_access(on_dmem, addr, fill_word(addr), 4'hf);
    end
  endtask

  task automatic strobe_sequence(input bit on_dmem, input addr_t base);
    strb_t strobes [4] = '{4'h1, 4'h6, 4'h8, 4'h5};
    for (int i = 0; i < 4; i++) begin
      port_access(on_dmem, base + 4 * (16 + i), $urandom, strobes[i]);
    end
    for (int i = 0; i < 4; i++) begin
      port_access(on_dmem, base + 4 * (16 + i), '0, '0);
    end
  endtask

  // Each port keeps to its own TIM words, so the model order is fixed.
  task automatic random_traffic(input bit on_dmem);
    addr_t       addr;
    strb_t       wstrb;
    int unsigned word;
    for (int n = 0; n < random_per_port; n++) begin
      wstrb = ($urandom_range(1, 0) == 1) ? strb_t'($urandom_range(15, 1)) : '0;
      word  = ($urandom_range(1023, 0) & ~32'd1) | on_dmem;
      case ($urandom_range(4, 0))
        0: addr = rom_base_addr + 4 * $urandom_range(1023, 0);
        1: addr = 32'h4000_0000 + ($urandom & 32'h0fff_fffc);
        2: addr = tim0_base_addr + 4 * word;
        default: addr = tim1_base_addr + 4 * word;
      endcase
      port_access(on_dmem, addr, $urandom, wstrb);
      repeat ($urandom_range(2, 0)) @(posedge clock);
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic finish_test();
    while (act_q.size() > 0) @(posedge clock);
    tests++;
    $display("test %s: %0d checks, %0d errors", cur_test, checks - test_checks,
             errors - test_errors);
  endtask

  initial begin
    void'($urandom(32'ha7870c67));
    clock      = 1'b0;
    arst_n     = 1'b0;
    imem_valid = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    imem_wstrb = '0;
    dmem_valid = 1'b0;
    dmem_addr  = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    repeat (5) @(posedge clock);
    arst_n <= 1'b1;

    start_test("tim_fill");
    fork
      fill_tim(1'b0);
      fill_tim(1'b1);
    join
    finish_test();

    start_test("rom_read_write");
    fork
      for (int k = 0; k < 8; k++) begin
        port_access(1'b0, rom_base_addr + 4 * k, '0, '0);
      end
      for (int k = 8; k < 16; k++) begin
        port_access(1'b1, rom_base_addr + 4 * k, '0, '0);
      end
    join
    for (int k = 5; k < 9; k++) begin
      port_access(k[0], rom_base_addr + 4 * k, 32'hdead_0000 + k, 4'hf);
    end
    for (int k = 5; k < 9; k++) begin
      port_access(!k[0], rom_base_addr + 4 * k, '0, '0);
    end
    finish_test();

    start_test("tim_strobes");
    fork
      strobe_sequence(1'b0, tim0_base_addr);
      strobe_sequence(1'b1, tim1_base_addr);
    join
    finish_test();

    start_test("tim_independence_alias");
    fork
      port_access(1'b0, tim0_base_addr + 32'h40, 32'h0a0a_0a0a, 4'hf);
      port_access(1'b1, tim1_base_addr + 32'h40, 32'h1b1b_1b1b, 4'hf);
    join
    port_access(1'b1, tim0_base_addr + 32'h40, '0, '0);
    port_access(1'b0, tim1_base_addr + 32'h40, '0, '0);
    port_access(1'b1, tim0_base_addr + 32'h40 + 4 * tim_words, 32'h2c2c_2c2c, 4'hf);
    port_access(1'b0, tim0_base_addr + 32'h40, '0, '0);
    finish_test();

    start_test("tim0_contention");
    for (int r = 0; r < 2; r++) begin
      fork
        port_access(1'b0, tim0_base_addr + 32'h80, 32'h3d3d_0001, r ? 4'h0 : 4'hf);
        port_access(1'b1, tim0_base_addr + 32'h84, 32'h4e4e_0002, r ? 4'h0 : 4'hf);
      join
      check_order(dmem_done, imem_done);
    end
    finish_test();

    start_test("unmapped");
    fork
      port_access(1'b0, 32'h3000_0000, '0, '0);
      port_access(1'b1, tim0_top_addr, '0, '0);
    join
    fork
      port_access(1'b0, 32'hffff_fff0, '0, '0);
      port_access(1'b1, tim1_top_addr + 32'h1000, '0, '0);
    join
    finish_test();

    start_test("random_mix");
    fork
      random_traffic(1'b0);
      random_traffic(1'b1);
    join
    finish_test();

    checker_fails = UUT.arbiter_rom_comp.arbiter_checks.fails
                  + UUT.arbiter_tim0_comp.arbiter_checks.fails
                  + UUT.arbiter_tim1_comp.arbiter_checks.fails;
    $display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             tests, checks, errors, checker_fails);
    if (errors == 0 && checker_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
soc_pkg.sv
bus_decoder.sv
port_arbiter.sv
tim.sv
boot_rom.sv
soc_fabric.sv
soc_fabric_checker.sv
tb_soc_fabric.sv

//--- Bender.yml
package:
  name: soc_fabric

sources:
  - soc_pkg.sv
  - bus_decoder.sv
  - port_arbiter.sv
  - tim.sv
  - boot_rom.sv
  - soc_fabric.sv
  - target: test
    files:
      - soc_fabric_checker.sv
      - tb_soc_fabric.sv
